//--- usb3_link_pkg.sv
package usb3_link_pkg;

	//////////////////////////////////////////////////
	// ltssm state codes
	//////////////////////////////////////////////////

	typedef logic [4:0] ltssm_t;

	// only the states the link-command path cares about
	localparam ltssm_t LT_POLLING_IDLE  = 5'd13;
	localparam ltssm_t LT_U0            = 5'd16;
	localparam ltssm_t LT_RECOVERY_IDLE = 5'd23;
	localparam ltssm_t LT_HOTRESET      = 5'd26;

	//////////////////////////////////////////////////
	// link command classes
	//////////////////////////////////////////////////

	// class and type bits of the command, top four bits of the word
	typedef logic [3:0] lcmd_class_t;

	localparam lcmd_class_t LGOOD = 4'b0000;
	localparam lcmd_class_t LCRD  = 4'b0001;
	localparam lcmd_class_t LRTY  = 4'b0010;
	localparam lcmd_class_t LBAD  = 4'b0011;
	localparam lcmd_class_t LGO_U = 4'b0100;
	localparam lcmd_class_t LAU   = 4'b0101;
	localparam lcmd_class_t LXU   = 4'b0110;
	localparam lcmd_class_t LPMA  = 4'b0111;
	localparam lcmd_class_t LUP   = 4'b1000;
	localparam lcmd_class_t LDN   = 4'b1011;
	// any other class value is undefined

	// sequence view, LGOOD_n and LGO_Un
	typedef struct packed {
		lcmd_class_t cls;
		logic [3:0]  spare;
		logic [2:0]  hdr_seq;
	} lcmd_seq_t;

	// credit view, LCRD_A..D
	typedef struct packed {
		lcmd_class_t cls;
		logic [4:0]  spare;
		logic [1:0]  cred_idx;
	} lcmd_cred_t;

	// one 11-bit command word, two readings
	typedef union packed {
		lcmd_seq_t  seq;
		lcmd_cred_t cred;
	} lcmd_word_u;

	//////////////////////////////////////////////////
	// lane and framing
	//////////////////////////////////////////////////

	// one 32-bit symbol beat with k-flags
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  datak;
		logic        active;
	} lcmd_beat_t;

	// link command ordered set, sent ahead of the command beat
	localparam logic [31:0] LCMD_FRAME_DATA = 32'hFEFEFEF7;
	localparam logic [3:0]  LCMD_FRAME_K    = 4'b1111;

	// crc-5 over the command, x^5 + x^2 + 1
	localparam logic [4:0] CRC5_POLY = 5'b00101;
	localparam logic [4:0] CRC5_SEED = 5'b11111;

	// remote header credits never exceed four
	localparam logic [2:0] CRED_MAX = 3'd4;

	// u0 entry advertisement, LGOOD_7 then LCRD_A..D
	localparam logic [2:0] ADV_HDR_SEQ = 3'd7;
	localparam logic [2:0] ADV_LAST    = 3'd4;

endpackage

//--- usb3_crc_cw.sv
`timescale 1ns/10ps

module usb3_crc_cw (
	input  logic [10:0] data,
	output logic [4:0]  crc
);

	import usb3_link_pkg::*;

	logic [4:0] lfsr;
	logic       fb;

	// serial crc unrolled over all eleven bits
	always_comb begin
		lfsr = CRC5_SEED;
		fb = 1'b0;
		// bit 0 goes out on the wire first
		for (int i = 0; i < 11; i++) begin
			fb = data[i] ^ lfsr[4];
			lfsr = {lfsr[3:0], 1'b0};
			if (fb) begin
				lfsr = lfsr ^ CRC5_POLY;
			end
		end
		// remainder sent inverted
		crc = ~lfsr;
	end

endmodule

//--- usb3_lcmd_rx.sv
`timescale 1ns/10ps

module usb3_lcmd_rx (
	input  logic                     local_clk,
	input  logic                     reset_n,
	input  usb3_link_pkg::lcmd_beat_t in_beat,
	output usb3_link_pkg::lcmd_word_u rx_cmd,
	output logic                     rx_cmd_valid,
	output logic                     err_lcmd_crc,
	output logic                     err_lcmd_undefined
);

	import usb3_link_pkg::*;

	typedef enum logic {
		RX_IDLE,
		RX_ARMED
	} rx_state_t;

	rx_state_t  state;
	logic       is_frame;
	// unswapped command beat and its strobe
	logic [31:0] cw;
	logic        cw_valid;
	lcmd_word_u  cw_cmd;
	logic [4:0]  crc_hi;
	logic [4:0]  crc_lo;
	logic        cw_good;
	logic        cls_defined;

	//////////////////////////////////////////////////
	// deframing
	//////////////////////////////////////////////////

	// FEFEFEF7 with all k-flags
	assign is_frame = in_beat.active &&
		(in_beat.data == LCMD_FRAME_DATA) &&
		(in_beat.datak == LCMD_FRAME_K);

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			state <= RX_IDLE;
			cw_valid <= 1'b0;
		end else begin
			cw_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (is_frame) begin
						state <= RX_ARMED;
					end
				end
				RX_ARMED: begin
					// inactive beats are skipped, stay armed
					if (in_beat.active) begin
						cw_valid <= 1'b1;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// byte swap inside each 16-bit half
	always_ff @(posedge local_clk) begin
		if (state == RX_ARMED && in_beat.active) begin
			cw <= {in_beat.data[23:16], in_beat.data[31:24],
				in_beat.data[7:0], in_beat.data[15:8]};
		end
	end

	//////////////////////////////////////////////////
	// checking and classification
	//////////////////////////////////////////////////

	assign cw_cmd = cw[10:0];

	// one checker per copy
	usb3_crc_cw crc_hi0 (
		.data (cw[26:16]),
		.crc  (crc_hi)
	);

	usb3_crc_cw crc_lo0 (
		.data (cw[10:0]),
		.crc  (crc_lo)
	);

	// both copies equal, both crc fields right
	assign cw_good = (cw[26:16] == cw[10:0]) &&
		(crc_hi == cw[31:27]) &&
		(crc_lo == cw[15:11]);

	always_comb begin
		case (cw_cmd.seq.cls)
			LGOOD, LCRD, LRTY, LBAD,
			LGO_U, LAU, LXU, LPMA,
			LUP, LDN: cls_defined = 1'b1;
			default:  cls_defined = 1'b0;
		endcase
	end

	// at most one of the three pulses per word
	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			rx_cmd_valid <= 1'b0;
			err_lcmd_crc <= 1'b0;
			err_lcmd_undefined <= 1'b0;
		end else begin
			rx_cmd_valid <= cw_valid && cw_good && cls_defined;
			err_lcmd_crc <= cw_valid && !cw_good;
			err_lcmd_undefined <= cw_valid && cw_good && !cls_defined;
		end
	end

	// command only loaded when it passes
	always_ff @(posedge local_clk) begin
		if (cw_valid && cw_good && cls_defined) begin
			rx_cmd <= cw_cmd;
		end
	end

endmodule

//--- usb3_lcmd_track.sv
`timescale 1ns/10ps

module usb3_lcmd_track (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  usb3_link_pkg::ltssm_t     ltssm_state,
	input  usb3_link_pkg::lcmd_word_u rx_cmd,
	input  logic                      rx_cmd_valid,
	output usb3_link_pkg::lcmd_word_u adv_cmd,
	output logic                      adv_valid,
	input  logic                      adv_ready,
	output logic [2:0]                remote_credits,
	output logic [2:0]                ack_hdr_seq,
	output logic                      err_cred_order
);

	import usb3_link_pkg::*;

	ltssm_t     ltssm_last;
	logic       u0_entry;
	logic       lose_state;
	logic       in_u0;
	// next LCRD index expected from the far end
	logic [1:0] exp_cred_idx;
	// advertisement step, 0 is LGOOD, 1..4 are LCRD_A..D
	logic [2:0] adv_idx;

	//////////////////////////////////////////////////
	// ltssm watch
	//////////////////////////////////////////////////

	assign in_u0 = (ltssm_state == LT_U0);
	// first cycle in U0, ltssm_last still holds the old state
	assign u0_entry = in_u0 && (ltssm_last != LT_U0);
	// fresh link, sequence state is lost too
	assign lose_state = (ltssm_last == LT_POLLING_IDLE) ||
		(ltssm_last == LT_HOTRESET);

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			ltssm_last <= LT_POLLING_IDLE;
		end else begin
			ltssm_last <= ltssm_state;
		end
	end

	//////////////////////////////////////////////////
	// advertisement sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			adv_valid <= 1'b0;
			adv_idx <= 3'd0;
		end else if (u0_entry) begin
			// restart from LGOOD on every entry
			adv_valid <= 1'b1;
			adv_idx <= 3'd0;
		end else if (adv_valid && adv_ready) begin
			if (adv_idx == ADV_LAST) begin
				adv_valid <= 1'b0;
			end else begin
				adv_idx <= adv_idx + 3'd1;
			end
		end
	end

	// command follows the step, stable while valid waits
	always_comb begin
		adv_cmd = '0;
		if (adv_idx == 3'd0) begin
			adv_cmd.seq.cls = LGOOD;
			adv_cmd.seq.hdr_seq = ADV_HDR_SEQ;
		end else begin
			adv_cmd.cred.cls = LCRD;
			adv_cmd.cred.cred_idx = 2'(adv_idx - 3'd1);
		end
	end

	//////////////////////////////////////////////////
	// received command accounting
	//////////////////////////////////////////////////

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			remote_credits <= 3'd0;
			ack_hdr_seq <= 3'd0;
			exp_cred_idx <= 2'd0;
			err_cred_order <= 1'b0;
		end else begin
			err_cred_order <= 1'b0;
			if (u0_entry) begin
				// credits always restart at A
				remote_credits <= 3'd0;
				exp_cred_idx <= 2'd0;
				if (lose_state) begin
					ack_hdr_seq <= 3'd0;
				end
			end else if (rx_cmd_valid && in_u0) begin
				case (rx_cmd.seq.cls)
					LGOOD: begin
						// wraps mod 8 in three bits
						ack_hdr_seq <= rx_cmd.seq.hdr_seq + 3'd1;
					end
					LCRD: begin
						if (rx_cmd.cred.cred_idx == exp_cred_idx) begin
							exp_cred_idx <= exp_cred_idx + 2'd1;
							if (remote_credits < CRED_MAX) begin
								remote_credits <= remote_credits + 3'd1;
							end
						end else begin
							// out of order, nothing counted
							err_cred_order <= 1'b1;
						end
					end
					// power commands pass through untouched
					default: ;
				endcase
			end
		end
	end

endmodule

//--- usb3_lcmd_tx.sv
`timescale 1ns/10ps

module usb3_lcmd_tx (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  usb3_link_pkg::lcmd_word_u adv_cmd,
	input  logic                      adv_valid,
	output logic                      adv_ready,
	input  usb3_link_pkg::lcmd_word_u user_cmd,
	input  logic                      user_valid,
	output logic                      user_ready,
	output usb3_link_pkg::lcmd_beat_t out_beat,
	input  logic                      out_stall
);

	import usb3_link_pkg::*;

	// state names the beat now on out_beat
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_FRAME,
		TX_CMD
	} tx_state_t;

	tx_state_t  state;
	tx_state_t  state_nxt;
	lcmd_beat_t beat_nxt;
	logic       slot_q;
	logic       slot_open;
	logic       accept;
	lcmd_word_u cmd_q;
	logic [4:0] cmd_crc;
	logic [15:0] half;

	//////////////////////////////////////////////////
	// arbitration
	//////////////////////////////////////////////////

	// no new command while framing is out or lane stalled
	assign slot_open = slot_q && !out_stall;
	assign adv_ready = slot_open;
	// advertisement wins
	assign user_ready = slot_open && !adv_valid;
	assign accept = slot_open && (adv_valid || user_valid);

	usb3_crc_cw crc0 (
		.data (cmd_q),
		.crc  (cmd_crc)
	);

	// {crc, cmd} with its two bytes swapped
	assign half = {cmd_q[7:0], cmd_crc, cmd_q[10:8]};

	//////////////////////////////////////////////////
	// beat writer
	//////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		beat_nxt = out_beat;
		// stall freezes everything
		if (!out_stall) begin
			case (state)
				TX_FRAME: begin
					state_nxt = TX_CMD;
					beat_nxt = '{data: {half, half}, datak: 4'b0000, active: 1'b1};
				end
				default: begin
					if (accept) begin
						state_nxt = TX_FRAME;
						beat_nxt = '{data: LCMD_FRAME_DATA, datak: LCMD_FRAME_K,
							active: 1'b1};
					end else begin
						state_nxt = TX_IDLE;
						beat_nxt = '{data: 32'h0, datak: 4'b0000, active: 1'b0};
					end
				end
			endcase
		end
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			state <= TX_IDLE;
			slot_q <= 1'b0;
			out_beat.active <= 1'b0;
		end else begin
			state <= state_nxt;
			// ready again once the command beat is going out
			slot_q <= (state_nxt != TX_FRAME);
			out_beat <= beat_nxt;
		end
	end

	always_ff @(posedge local_clk) begin
		if (accept) begin
			cmd_q <= adv_valid ? adv_cmd : user_cmd;
		end
	end

endmodule

//--- usb3_link.sv
`timescale 1ns/10ps

module usb3_link (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  usb3_link_pkg::ltssm_t     ltssm_state,
	input  usb3_link_pkg::lcmd_beat_t in_beat,
	output usb3_link_pkg::lcmd_beat_t out_beat,
	input  logic                      out_stall,
	input  usb3_link_pkg::lcmd_word_u user_cmd,
	input  logic                      user_valid,
	output logic                      user_ready,
	output usb3_link_pkg::lcmd_word_u rx_cmd,
	output logic                      rx_cmd_valid,
	output logic [2:0]                remote_credits,
	output logic [2:0]                ack_hdr_seq,
	output logic                      err_lcmd_crc,
	output logic                      err_lcmd_undefined,
	output logic                      err_cred_order
);

	// advertisement handshake, track to tx
	usb3_link_pkg::lcmd_word_u adv_cmd;
	logic                      adv_valid;
	logic                      adv_ready;

	// receive side, no back-pressure
	usb3_lcmd_rx rx0 (
		.local_clk          (local_clk),
		.reset_n            (reset_n),
		.in_beat            (in_beat),
		.rx_cmd             (rx_cmd),
		.rx_cmd_valid       (rx_cmd_valid),
		.err_lcmd_crc       (err_lcmd_crc),
		.err_lcmd_undefined (err_lcmd_undefined)
	);

	// credits, sequence and u0 entry
	usb3_lcmd_track track0 (
		.local_clk      (local_clk),
		.reset_n        (reset_n),
		.ltssm_state    (ltssm_state),
		.rx_cmd         (rx_cmd),
		.rx_cmd_valid   (rx_cmd_valid),
		.adv_cmd        (adv_cmd),
		.adv_valid      (adv_valid),
		.adv_ready      (adv_ready),
		.remote_credits (remote_credits),
		.ack_hdr_seq    (ack_hdr_seq),
		.err_cred_order (err_cred_order)
	);

	// framing writer onto the lane
	usb3_lcmd_tx tx0 (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.adv_cmd    (adv_cmd),
		.adv_valid  (adv_valid),
		.adv_ready  (adv_ready),
		.user_cmd   (user_cmd),
		.user_valid (user_valid),
		.user_ready (user_ready),
		.out_beat   (out_beat),
		.out_stall  (out_stall)
	);

endmodule

//--- tb_usb3_link_check.sv
`timescale 1ns/10ps

module tb_usb3_link_check (
	input  logic                      local_clk,
	input  logic                      reset_n,
	input  usb3_link_pkg::lcmd_beat_t out_beat,
	input  logic                      out_stall,
	input  usb3_link_pkg::lcmd_word_u rx_cmd,
	input  logic                      rx_cmd_valid,
	input  logic                      err_lcmd_crc,
	input  logic                      err_lcmd_undefined,
	input  logic [2:0]                remote_credits,
	input  logic [2:0]                ack_hdr_seq,
	input  logic                      err_cred_order,
	output int                        errors
);

	import usb3_link_pkg::*;

	// one expected receive event, kind is one-hot {undefined, crc, valid}
	typedef struct packed {
		logic [2:0]  kind;
		logic [10:0] cmd;
		logic [2:0]  credits;
		logic [2:0]  ack;
		logic        order;
	} rx_exp_t;

	rx_exp_t     rx_q[$];
	string       rx_name_q[$];
	logic [10:0] tx_q[$];
	string       tx_name_q[$];
	// {credits, ack} status checks asked for by the stimulus
	logic [5:0]  st_q[$];
	string       st_name_q[$];
	rx_exp_t     pend;
	string       pend_name;
	logic        pend_on = 1'b0;
	// high between framing beat and command beat
	logic        cmd_phase = 1'b0;
	logic [2:0]  rx_kind;
	logic [10:0] tx_cmd;
	string       tx_name;
	logic [5:0]  st_exp;
	string       st_name;
	int          err_count = 0;

	assign errors = err_count;

	//////////////////////////////////////////////////
	// reference model of the lane
	//////////////////////////////////////////////////

	// crc-5, x^5+x^2+1, seed all ones, bit 0 first, remainder inverted
	function automatic logic [4:0] crc5(input logic [10:0] d);
		logic [4:0] r;
		logic       fb;
		r = 5'h1f;
		for (int i = 0; i < 11; i++) begin
			fb = d[i] ^ r[4];
			r = {r[3], r[2], r[1] ^ fb, r[0], fb};
		end
		return ~r;
	endfunction

	// {crc, cmd} with its bytes swapped, same copy in both halves
	function automatic logic [31:0] lane_word(input logic [10:0] cmd);
		logic [15:0] h;
		h = {crc5(cmd), cmd};
		return {h[7:0], h[15:8], h[7:0], h[15:8]};
	endfunction

	//////////////////////////////////////////////////
	// expectations from the stimulus
	//////////////////////////////////////////////////

	task automatic expect_rx(input string name, input logic [2:0] kind,
		input logic [10:0] cmd, input logic [2:0] credits, input logic [2:0] ack,
		input logic order);
		rx_exp_t e;
		e.kind = kind;
		e.cmd = cmd;
		e.credits = credits;
		e.ack = ack;
		e.order = order;
		rx_q.push_back(e);
		rx_name_q.push_back(name);
	endtask

	task automatic expect_tx(input string name, input logic [10:0] cmd);
		tx_q.push_back(cmd);
		tx_name_q.push_back(name);
	endtask

	task automatic check_status(input string name, input logic [2:0] credits,
		input logic [2:0] ack);
		st_q.push_back({credits, ack});
		st_name_q.push_back(name);
	endtask

	// nothing left to see
	function automatic logic idle();
		return (rx_q.size() == 0) && (tx_q.size() == 0) && (st_q.size() == 0) &&
			!pend_on && !cmd_phase;
	endfunction

	task automatic mismatch(input string name, input string what, input logic [39:0] exp,
		input logic [39:0] act);
		err_count++;
		$display("mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
	endtask

	//////////////////////////////////////////////////
	// watcher
	//////////////////////////////////////////////////

	always @(posedge local_clk) begin
		if (!reset_n) begin
			pend_on = 1'b0;
			cmd_phase = 1'b0;
		end else begin
			// status one cycle after the received word
			if (pend_on) begin
				if (remote_credits !== pend.credits) begin
					mismatch(pend_name, "remote_credits", 40'(pend.credits), 40'(remote_credits));
				end
				if (ack_hdr_seq !== pend.ack) begin
					mismatch(pend_name, "ack_hdr_seq", 40'(pend.ack), 40'(ack_hdr_seq));
				end
				if (err_cred_order !== pend.order) begin
					mismatch(pend_name, "err_cred_order", 40'(pend.order), 40'(err_cred_order));
				end
				pend_on = 1'b0;
			end else if (err_cred_order !== 1'b0) begin
				err_count++;
				$display("err_cred_order pulsed with no received command before it");
			end
			// pulses from the receiver
			rx_kind = {err_lcmd_undefined, err_lcmd_crc, rx_cmd_valid};
			if (rx_kind !== 3'b000) begin
				if (rx_q.size() == 0) begin
					err_count++;
					$display("receiver pulsed with no command expected");
				end else begin
					pend = rx_q.pop_front();
					pend_name = rx_name_q.pop_front();
					pend_on = 1'b1;
					if (rx_kind !== pend.kind) begin
						mismatch(pend_name, "rx event", 40'(pend.kind), 40'(rx_kind));
					end else if (pend.kind[0] && (rx_cmd !== pend.cmd)) begin
						mismatch(pend_name, "rx_cmd", 40'(pend.cmd), 40'(rx_cmd));
					end
				end
			end
			// requested status
			if (st_q.size() != 0) begin
				st_exp = st_q.pop_front();
				st_name = st_name_q.pop_front();
				if (remote_credits !== st_exp[5:3]) begin
					mismatch(st_name, "remote_credits", 40'(st_exp[5:3]), 40'(remote_credits));
				end
				if (ack_hdr_seq !== st_exp[2:0]) begin
					mismatch(st_name, "ack_hdr_seq", 40'(st_exp[2:0]), 40'(ack_hdr_seq));
				end
			end
			// a beat only counts once the lane takes it
			if (!out_stall && out_beat.active) begin
				if (!cmd_phase) begin
					if (tx_q.size() == 0) begin
						err_count++;
						$display("beat on out_beat with no command expected");
					end else if ({out_beat.data, out_beat.datak} !==
						{LCMD_FRAME_DATA, LCMD_FRAME_K}) begin
						mismatch(tx_name_q[0], "framing beat", {LCMD_FRAME_DATA, LCMD_FRAME_K},
							40'({out_beat.data, out_beat.datak}));
					end
					cmd_phase = 1'b1;
				end else begin
					if (tx_q.size() != 0) begin
						tx_cmd = tx_q.pop_front();
						tx_name = tx_name_q.pop_front();
						if ({out_beat.data, out_beat.datak} !== {lane_word(tx_cmd), 4'h0}) begin
							mismatch(tx_name, "command beat", 40'({lane_word(tx_cmd), 4'h0}),
								40'({out_beat.data, out_beat.datak}));
						end
					end
					cmd_phase = 1'b0;
				end
			end
		end
	end

endmodule

//--- tb_usb3_link.sv
`timescale 1ns/10ps

module tb_usb3_link;

	import usb3_link_pkg::*;

	// table actions
	localparam logic [2:0] ACT_LTSSM   = 3'd0;
	localparam logic [2:0] ACT_RX      = 3'd1;
	localparam logic [2:0] ACT_CORRUPT = 3'd2;
	localparam logic [2:0] ACT_USER    = 3'd3;
	localparam logic [2:0] ACT_STALL   = 3'd4;
	localparam logic [2:0] ACT_SETTLE  = 3'd5;
	localparam int WAIT_LIMIT = 400;

	// one table row, arg is ltssm code, idle gap or stall window
	typedef struct packed {
		logic [2:0]  act;
		logic [10:0] cmd;
		logic [7:0]  arg;
		logic [2:0]  credits;
		logic [2:0]  ack;
		logic        order;
	} step_t;

	logic        local_clk = 1'b0;
	logic        reset_n;
	ltssm_t      ltssm_state;
	lcmd_beat_t  in_beat;
	lcmd_beat_t  out_beat;
	logic        out_stall;
	lcmd_word_u  user_cmd;
	logic        user_valid;
	logic        user_ready;
	lcmd_word_u  rx_cmd;
	logic        rx_cmd_valid;
	logic [2:0]  remote_credits;
	logic [2:0]  ack_hdr_seq;
	logic        err_lcmd_crc;
	logic        err_lcmd_undefined;
	logic        err_cred_order;
	int          check_errors;
	int          timeouts = 0;
	logic [31:0] lfsr_state;
	int          stall_window = 0;
	step_t       steps[$];
	string       names[$];

	always #50 local_clk = ~local_clk;

	usb3_link dut0 (.*);

	tb_usb3_link_check chk0 (.*, .errors(check_errors));

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[6:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [10:0] seq_word(input logic [3:0] cls, input logic [2:0] n);
		return {cls, 4'b0000, n};
	endfunction

	function automatic logic [10:0] cred_word(input logic [3:0] cls, input logic [1:0] idx);
		return {cls, 5'b00000, idx};
	endfunction

	// the ten classes the standard names
	function automatic logic class_defined(input logic [3:0] cls);
		case (cls)
			LGOOD, LCRD, LRTY, LBAD, LGO_U, LAU, LXU, LPMA, LUP, LDN: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// falling edge, random out_stall while a window is open
	task automatic next_cycle();
		logic [7:0] b;
		@(negedge local_clk);
		if (stall_window > 0) begin
			stall_window--;
			take_bits(1, b);
			out_stall = b[0];
		end else begin
			out_stall = 1'b0;
		end
	endtask

	// framing beat, inactive gap, command beat
	task automatic send_word(input logic [31:0] data, input int gap);
		in_beat = '{data: LCMD_FRAME_DATA, datak: LCMD_FRAME_K, active: 1'b1};
		next_cycle();
		for (int i = 0; i < gap; i++) begin
			in_beat = '0;
			next_cycle();
		end
		in_beat = '{data: data, datak: 4'h0, active: 1'b1};
		next_cycle();
		in_beat = '0;
	endtask

	task automatic wait_settle(input string name);
		int t;
		t = 0;
		while (!chk0.idle() && t < WAIT_LIMIT) begin
			next_cycle();
			t++;
		end
		if (!chk0.idle()) begin
			timeouts++;
			$display("timeout in %s, expected DUT output never arrived", name);
		end
	endtask

	// ready read a little after the falling edge, stable until the rising one
	task automatic send_user(input string name, input logic [10:0] cmd);
		int   t;
		logic done;
		t = 0;
		done = 1'b0;
		chk0.expect_tx(name, cmd);
		user_cmd = cmd;
		user_valid = 1'b1;
		while (!done && t < WAIT_LIMIT) begin
			#1;
			done = user_ready;
			next_cycle();
			t++;
		end
		user_valid = 1'b0;
		if (!done) begin
			timeouts++;
			$display("timeout in %s, user_ready never came", name);
		end
	endtask

	task automatic add(input string name, input logic [2:0] act, input logic [10:0] cmd,
		input logic [7:0] arg, input logic [2:0] credits, input logic [2:0] ack,
		input logic order);
		step_t s;
		s.act = act;
		s.cmd = cmd;
		s.arg = arg;
		s.credits = credits;
		s.ack = ack;
		s.order = order;
		steps.push_back(s);
		names.push_back(name);
	endtask

	//////////////////////////////////////////////////
	// stimulus table, expected credits and ack after each row
	//////////////////////////////////////////////////

	task automatic build_table();
		add("u0 from polling", ACT_LTSSM, 11'd0, 8'(LT_U0), 3'd0, 3'd0, 1'b0);
		add("advertisement", ACT_SETTLE, 11'd0, 8'd0, 3'd0, 3'd0, 1'b0);
		add("lgood_2", ACT_RX, seq_word(LGOOD, 3'd2), 8'd0, 3'd0, 3'd3, 1'b0);
		add("lcrd_a", ACT_RX, cred_word(LCRD, 2'd0), 8'd0, 3'd1, 3'd3, 1'b0);
		add("lcrd_b", ACT_RX, cred_word(LCRD, 2'd1), 8'd0, 3'd2, 3'd3, 1'b0);
		add("lcrd_c", ACT_RX, cred_word(LCRD, 2'd2), 8'd0, 3'd3, 3'd3, 1'b0);
		add("lcrd_d", ACT_RX, cred_word(LCRD, 2'd3), 8'd0, 3'd4, 3'd3, 1'b0);
		// index wraps, count stays at the limit
		add("lcrd_a saturate", ACT_RX, cred_word(LCRD, 2'd0), 8'd0, 3'd4, 3'd3, 1'b0);
		add("lcrd_c order", ACT_RX, cred_word(LCRD, 2'd2), 8'd0, 3'd4, 3'd3, 1'b1);
		add("lgood_7 wrap", ACT_RX, seq_word(LGOOD, 3'd7), 8'd0, 3'd4, 3'd0, 1'b0);
		add("lrty", ACT_RX, seq_word(LRTY, 3'd0), 8'd0, 3'd4, 3'd0, 1'b0);
		add("bit flip", ACT_CORRUPT, seq_word(LGOOD, 3'd5), 8'd0, 3'd4, 3'd0, 1'b0);
		add("undefined", ACT_RX, seq_word(4'b1001, 3'd0), 8'd0, 3'd4, 3'd0, 1'b0);
		add("lgood_4 gap", ACT_RX, seq_word(LGOOD, 3'd4), 8'd3, 3'd4, 3'd5, 1'b0);
		add("recovery", ACT_LTSSM, 11'd0, 8'(LT_RECOVERY_IDLE), 3'd4, 3'd5, 1'b0);
		// outside U0 nothing moves
		add("lgood_1 recovery", ACT_RX, seq_word(LGOOD, 3'd1), 8'd0, 3'd4, 3'd5, 1'b0);
		add("u0 from recovery", ACT_LTSSM, 11'd0, 8'(LT_U0), 3'd0, 3'd5, 1'b0);
		add("user lrty", ACT_USER, seq_word(LRTY, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("user lgo_u3", ACT_USER, seq_word(LGO_U, 3'd3), 8'd0, 3'd0, 3'd5, 1'b0);
		add("after advertisement", ACT_SETTLE, 11'd0, 8'd0, 3'd0, 3'd5, 1'b0);
		add("random stall", ACT_STALL, 11'd0, 8'd80, 3'd0, 3'd5, 1'b0);
		add("user lau", ACT_USER, seq_word(LAU, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("user lxu", ACT_USER, seq_word(LXU, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("user lpma", ACT_USER, seq_word(LPMA, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("user lup", ACT_USER, seq_word(LUP, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("user ldn", ACT_USER, seq_word(LDN, 3'd0), 8'd0, 3'd0, 3'd5, 1'b0);
		add("stalled beats", ACT_SETTLE, 11'd0, 8'd0, 3'd0, 3'd5, 1'b0);
		// index restarted at A on the last entry
		add("lcrd_a after recovery", ACT_RX, cred_word(LCRD, 2'd0), 8'd0, 3'd1, 3'd5, 1'b0);
		add("hotreset", ACT_LTSSM, 11'd0, 8'(LT_HOTRESET), 3'd1, 3'd5, 1'b0);
		// credit below the limit and index in order, still nothing counted
		add("lgood_1 hotreset", ACT_RX, seq_word(LGOOD, 3'd1), 8'd0, 3'd1, 3'd5, 1'b0);
		add("lcrd_b hotreset", ACT_RX, cred_word(LCRD, 2'd1), 8'd0, 3'd1, 3'd5, 1'b0);
		add("u0 from hotreset", ACT_LTSSM, 11'd0, 8'(LT_U0), 3'd0, 3'd0, 1'b0);
		add("lcrd_a fresh", ACT_RX, cred_word(LCRD, 2'd0), 8'd0, 3'd1, 3'd0, 1'b0);
		add("last advertisement", ACT_SETTLE, 11'd0, 8'd0, 3'd1, 3'd0, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		step_t      s;
		string      name;
		logic [7:0] b;
		reset_n = 1'b0;
		ltssm_state = LT_POLLING_IDLE;
		in_beat = '0;
		out_stall = 1'b0;
		user_cmd = '0;
		user_valid = 1'b0;
		lfsr_state = 32'h74da;
		build_table();
		repeat (5) next_cycle();
		reset_n = 1'b1;
		next_cycle();
		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			name = names[i];
			case (s.act)
				ACT_LTSSM: begin
					// fresh entry to U0 sends LGOOD_7 then LCRD_A..D
					if (s.arg[4:0] == LT_U0 && ltssm_state != LT_U0) begin
						chk0.expect_tx({name, " lgood_7"}, seq_word(LGOOD, 3'd7));
						for (int k = 0; k < 4; k++) begin
							chk0.expect_tx($sformatf("%s lcrd_%0d", name, k),
								cred_word(LCRD, 2'(k)));
						end
					end
					ltssm_state = s.arg[4:0];
					next_cycle();
					next_cycle();
					chk0.check_status(name, s.credits, s.ack);
				end
				ACT_RX: begin
					chk0.expect_rx(name, class_defined(s.cmd[10:7]) ? 3'b001 : 3'b100,
						s.cmd, s.credits, s.ack, s.order);
					send_word(chk0.lane_word(s.cmd), int'(s.arg));
					wait_settle(name);
				end
				ACT_CORRUPT: begin
					take_bits(5, b);
					chk0.expect_rx(name, 3'b010, s.cmd, s.credits, s.ack, 1'b0);
					send_word(chk0.lane_word(s.cmd) ^ (32'h1 << b[4:0]), 0);
					wait_settle(name);
				end
				ACT_USER: send_user(name, s.cmd);
				ACT_STALL: stall_window = int'(s.arg);
				ACT_SETTLE: wait_settle(name);
				default: $display("unknown action in table row %s", name);
			endcase
		end
		wait_settle("end of table");
		// room for any late pulse
		repeat (4) next_cycle();
		$display("errors: %0d mismatches, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- src.f
usb3_link_pkg.sv
usb3_crc_cw.sv
usb3_lcmd_rx.sv
usb3_lcmd_track.sv
usb3_lcmd_tx.sv
usb3_link.sv
tb_usb3_link_check.sv
tb_usb3_link.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_usb3_link
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
